//--- verilog/pwm_params.svh
// sizes shared by every block of the PWM subsystem.
// the channel field width follows PWM_CHANNELS and must match the command layout.
// a 24-bit command leaves 4 spare bits in the set-times view.

`ifndef PWM_PARAMS_SVH
`define PWM_PARAMS_SVH

// ============================================================
// subsystem sizes
// ============================================================
`define PWM_CHANNELS 4                    // number of channels.
`define PWM_CHAN_W   $clog2(`PWM_CHANNELS) // channel field width.
`define PWM_TIME_W   8                    // on time and period width.
`define PWM_CMD_W    24                   // host command word.
`define PWM_CNT_W    8                    // completed period counter.

`endif

//--- verilog/pwm_pkg.sv
// types shared by the PWM command decoder, channels and status block.
// opcode 2'b11 has no meaning and is rejected by the decoder.

`include "pwm_params.svh"

package pwm_pkg;

  typedef enum logic [1:0] {
    OP_SET_TIMES   = 2'b00,
    OP_ENABLE      = 2'b01,
    OP_READ_STATUS = 2'b10
  } pwm_op_e;

  // ============================================================
  // command word views
  // ============================================================
  typedef struct packed {
    pwm_op_e                 op;
    logic [`PWM_CHAN_W-1:0]  chan;
    logic [`PWM_TIME_W-1:0]  t_on;
    logic [`PWM_TIME_W-1:0]  t_period;
    logic [`PWM_CMD_W-2-`PWM_CHAN_W-2*`PWM_TIME_W-1:0] spare;
  } pwm_cfg_t;

  typedef struct packed {
    pwm_op_e                  op;    // same bits as in cfg.
    logic [`PWM_CHAN_W-1:0]   chan;
    logic [`PWM_CHANNELS-1:0] en_mask;
    logic [`PWM_CMD_W-2-`PWM_CHAN_W-`PWM_CHANNELS-1:0] spare;
  } pwm_ctl_t;

  typedef union packed {
    pwm_cfg_t cfg;
    pwm_ctl_t ctl;
  } pwm_cmd_u;

  typedef struct packed {
    logic [`PWM_TIME_W-1:0] t_on;
    logic [`PWM_TIME_W-1:0] t_period;
  } pwm_times_t;

  typedef struct packed {
    logic                  ok;
    logic                  enabled;
    logic [`PWM_CNT_W-1:0] data;
  } pwm_resp_t;

endpackage

//--- verilog/pwm_cmd_decoder.sv
// host command decoder with a four-phase req/ack link.
// cmd must stay stable while req is high. a new command is taken only
// after ack has fallen. set-times needs 1 <= t_on < t_period.
// shadow times reset to t_on=1 and t_period=2.

`timescale 1ns/1ps
`include "pwm_params.svh"

module pwm_cmd_decoder (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req,
  input  pwm_pkg::pwm_cmd_u        cmd,
  output logic                     ack,
  output pwm_pkg::pwm_times_t      times [`PWM_CHANNELS],
  output logic [`PWM_CHANNELS-1:0] enable,
  output logic                     status_req,
  output logic [`PWM_CHAN_W-1:0]   status_chan,
  output logic                     cmd_ok
);

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_HOLD, S_DROP} hs_state_e;

  hs_state_e              hs_state;
  pwm_pkg::pwm_op_e       op;
  logic [`PWM_CHAN_W-1:0] chan;
  logic                   exec;
  logic                   times_ok;
  logic                   legal;

  // ============================================================
  // four-phase handshake
  // ============================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      hs_state <= S_IDLE;
    end else begin
      case (hs_state)
        S_IDLE: if (req) hs_state <= S_EXEC;
        S_EXEC: hs_state <= S_HOLD;  // command acts on this edge.
        S_HOLD: if (!req) hs_state <= S_DROP;
        default: hs_state <= S_IDLE; // ack drops here.
      endcase
    end
  end

  assign ack  = (hs_state == S_HOLD) || (hs_state == S_DROP);
  assign exec = (hs_state == S_EXEC);

  // ============================================================
  // decode and checks
  // ============================================================
  assign op       = cmd.cfg.op;   // op sits in the same place in both views.
  assign chan     = cmd.cfg.chan;
  assign times_ok = (cmd.cfg.t_on != '0) && (cmd.cfg.t_on < cmd.cfg.t_period);

  always_comb begin
    case (op)
      pwm_pkg::OP_SET_TIMES:   legal = times_ok;
      pwm_pkg::OP_ENABLE:      legal = 1'b1;
      pwm_pkg::OP_READ_STATUS: legal = 1'b1;
      default:                 legal = 1'b0;
    endcase
  end

  assign cmd_ok      = exec && legal;
  assign status_req  = exec && (op == pwm_pkg::OP_READ_STATUS);
  assign status_chan = chan;

  // shadow times and enable mask.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < `PWM_CHANNELS; i++) begin
        times[i] <= '{t_on: `PWM_TIME_W'(1), t_period: `PWM_TIME_W'(2)};
      end
      enable <= '0;
    end else if (cmd_ok) begin
      if (op == pwm_pkg::OP_SET_TIMES) begin
        times[chan] <= '{t_on: cmd.cfg.t_on, t_period: cmd.cfg.t_period};
      end
      if (op == pwm_pkg::OP_ENABLE) begin
        enable <= cmd.ctl.en_mask; // whole mask replaced.
      end
    end
  end

endmodule

//--- verilog/pwm_channel.sv
// one PWM channel as a Moore FSM with built-in down-counters.
// a period is IDLE, CONFIG, t_on cycles of ON and t_period - t_on of OFF.
// times are sampled only in CONFIG. assumes 1 <= t_on < t_period.

`timescale 1ns/1ps
`include "pwm_params.svh"

module pwm_channel (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  pwm_pkg::pwm_times_t times,
  output logic                pwm_out,
  output logic                period_done
);

  typedef enum logic [1:0] {IDLE, CONFIG, ON, OFF} state_e;

  state_e                 state;
  state_e                 next_state;
  logic [`PWM_TIME_W-1:0] on_cnt;
  logic [`PWM_TIME_W-1:0] per_cnt;
  logic                   on_last;
  logic                   per_last;

  assign on_last  = (on_cnt == `PWM_TIME_W'(1));
  assign per_last = (per_cnt == `PWM_TIME_W'(1));

  // ============================================================
  // state register and next state
  // ============================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    unique case (state)
      IDLE: begin
        if (enable) next_state = CONFIG; // disable only takes effect here.
      end
      CONFIG: begin
        next_state = ON;
      end
      ON: begin
        if (on_last) next_state = OFF;
      end
      OFF: begin
        if (per_last) next_state = IDLE;
      end
    endcase
  end

  // ============================================================
  // down-counters
  // ============================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      on_cnt  <= '0;
      per_cnt <= '0;
    end else begin
      case (state)
        CONFIG: begin
          on_cnt  <= times.t_on;      // reload from shadow.
          per_cnt <= times.t_period;
        end
        ON: begin
          on_cnt  <= on_cnt - 1'b1;
          per_cnt <= per_cnt - 1'b1;
        end
        OFF: begin
          per_cnt <= per_cnt - 1'b1;  // only the period runs.
        end
        default: begin
          on_cnt  <= on_cnt;
          per_cnt <= per_cnt;
        end
      endcase
    end
  end

  // outputs.
  assign pwm_out     = (state == ON);
  assign period_done = (state == OFF) && per_last; // last OFF cycle.

endmodule

//--- verilog/pwm_status.sv
// completed period counters and the host response word.
// counts wrap modulo 256 and are never cleared by a read.
// a rejected command leaves resp all zero, so ok reads 0.

`timescale 1ns/1ps
`include "pwm_params.svh"

module pwm_status (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`PWM_CHANNELS-1:0] period_done,
  input  logic [`PWM_CHANNELS-1:0] enable,
  input  logic                     status_req,
  input  logic [`PWM_CHAN_W-1:0]   status_chan,
  input  logic                     cmd_ok,
  input  logic                     ack,
  output pwm_pkg::pwm_resp_t       resp
);

  logic [`PWM_CNT_W-1:0] count [`PWM_CHANNELS];
  logic                  ack_q;

  // ============================================================
  // period counters
  // ============================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < `PWM_CHANNELS; i++) begin
        count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `PWM_CHANNELS; i++) begin
        if (period_done[i]) count[i] <= count[i] + 1'b1;
      end
    end
  end

  // response word, held while ack is high.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      ack_q <= 1'b0;
      resp  <= '0;
    end else begin
      ack_q <= ack;
      if (cmd_ok) begin
        resp.ok      <= 1'b1;
        resp.enabled <= enable[status_chan];
        resp.data    <= status_req ? count[status_chan] : '0; // reads only.
      end else if (ack_q && !ack) begin
        resp <= '0;  // ack fell.
      end
    end
  end

endmodule

//--- verilog/pwm_unit.sv
// top of the PWM subsystem.
// decode stage, PWM_CHANNELS channel copies, and the status stage.
// host link is four-phase req/ack with a 24-bit command word.

`timescale 1ns/1ps
`include "pwm_params.svh"

module pwm_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req,
  input  pwm_pkg::pwm_cmd_u        cmd,
  output logic                     ack,
  output pwm_pkg::pwm_resp_t       resp,
  output logic [`PWM_CHANNELS-1:0] pwm_out
);

  pwm_pkg::pwm_times_t      times [`PWM_CHANNELS];
  logic [`PWM_CHANNELS-1:0] enable;
  logic [`PWM_CHANNELS-1:0] period_done;
  logic                     status_req;
  logic [`PWM_CHAN_W-1:0]   status_chan;
  logic                     cmd_ok;

  // ============================================================
  // decode
  // ============================================================
  pwm_cmd_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .cmd         (cmd),
    .ack         (ack),
    .times       (times),
    .enable      (enable),
    .status_req  (status_req),
    .status_chan (status_chan),
    .cmd_ok      (cmd_ok)
  );

  // one FSM per channel.
  for (genvar i = 0; i < `PWM_CHANNELS; i++) begin : g_chan
    pwm_channel u_chan (
      .clk         (clk),
      .reset       (reset),
      .enable      (enable[i]),
      .times       (times[i]),
      .pwm_out     (pwm_out[i]),
      .period_done (period_done[i])
    );
  end

  pwm_status u_status (
    .clk         (clk),
    .reset       (reset),
    .period_done (period_done),
    .enable      (enable),
    .status_req  (status_req),
    .status_chan (status_chan),
    .cmd_ok      (cmd_ok),
    .ack         (ack),
    .resp        (resp)
  );

endmodule

//--- sim/pwm_unit_props.sv
// handshake and output assertions, bound into pwm_unit.
// a pwm_out rise needs enable high two cycles earlier (IDLE, CONFIG, ON).

`timescale 1ns/1ps
`include "pwm_params.svh"

module pwm_unit_props (
  input logic                     clk,
  input logic                     reset,
  input logic                     req,
  input logic                     ack,
  input pwm_pkg::pwm_cmd_u        cmd,
  input logic [`PWM_CHANNELS-1:0] enable,
  input logic [`PWM_CHANNELS-1:0] pwm_out
);

  // ============================================================
  // host link
  // ============================================================
  ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
    $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  cmd_held: assert property (@(posedge clk) disable iff (!reset)
    (req && $past(req)) |-> $stable(cmd))
    else $error("cmd changed while req was high");

  // an idle channel with enable low never starts a pulse.
  for (genvar i = 0; i < `PWM_CHANNELS; i++) begin : g_out
    idle_low: assert property (@(posedge clk) disable iff (!reset)
      $rose(pwm_out[i]) |-> $past(enable[i], 2))
      else $error("pwm_out %0d started while its enable was low", i);
  end

endmodule

bind pwm_unit pwm_unit_props props (
  .clk     (clk),
  .reset   (reset),
  .req     (req),
  .ack     (ack),
  .cmd     (cmd),
  .enable  (enable),
  .pwm_out (pwm_out)
);

//--- sim/pwm_unit_tb.sv
// testbench for the PWM subsystem, driven from a table of host commands.
// inputs change on falling edges, results are sampled on falling edges.
// count checks assume all channels were enabled by the first enable command.

`timescale 1ns/1ps
`include "pwm_params.svh"

module pwm_unit_tb;

  typedef struct {
    string             name;
    pwm_pkg::pwm_cmd_u cmd;
    int                exp_ok;
    int                exp_en;    // -1 skips the check.
    int                exp_data;  // -1 skips, -2 means same as last read.
    int                cnt_tp;    // nonzero: data from the period count.
    int                sync_chan; // wait for a rising pwm_out first.
    int                wait_cyc;
    int                tim_chan;  // channel whose pulse timing is checked.
    int                exp_width;
    int                exp_space;
  } row_t;

  logic                     clk;
  logic                     reset;
  logic                     req;
  pwm_pkg::pwm_cmd_u        cmd;
  logic                     ack;
  pwm_pkg::pwm_resp_t       resp;
  logic [`PWM_CHANNELS-1:0] pwm_out;

  row_t rows [$];
  int   errors;
  int   cycle;
  int   en_cycle;
  int   last_data;
  int   limit;
  bit   table_ready;
  bit   prev_out   [`PWM_CHANNELS];
  int   high_cnt   [`PWM_CHANNELS];
  int   since_rise [`PWM_CHANNELS];
  int   last_width [`PWM_CHANNELS];
  int   last_space [`PWM_CHANNELS];

  pwm_unit dut (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .cmd     (cmd),
    .ack     (ack),
    .resp    (resp),
    .pwm_out (pwm_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ============================================================
  // pulse monitor, high width and rise to rise spacing
  // ============================================================
  always @(negedge clk) begin
    for (int i = 0; i < `PWM_CHANNELS; i++) begin
      since_rise[i]++;
      if (pwm_out[i] && !prev_out[i]) begin
        last_space[i] = since_rise[i];
        since_rise[i] = 0;
        high_cnt[i]   = 0;
      end
      if (pwm_out[i]) high_cnt[i]++;
      if (!pwm_out[i] && prev_out[i]) last_width[i] = high_cnt[i];
      prev_out[i] = pwm_out[i];
    end
  end

  task automatic check(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s expected %0d actual %0d", name, expected, actual);
      $display("sim failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // one four-phase exchange, resp is captured while ack is high.
  task automatic exchange(input pwm_pkg::pwm_cmd_u c, output int ok, output int en,
                          output int data, output int at_cyc);
    @(negedge clk);
    cmd = c;
    req = 1'b1;
    do @(negedge clk); while (!ack);
    at_cyc = cycle;
    ok     = int'(resp.ok);
    en     = int'(resp.enabled);
    data   = int'(resp.data);
    req    = 1'b0;
    do @(negedge clk); while (ack);
  endtask

  task automatic wait_rise(input int ch);
    @(negedge clk);
    while (pwm_out[ch]) @(negedge clk);
    while (!pwm_out[ch]) @(negedge clk);
  endtask

  // ============================================================
  // command words
  // ============================================================
  function automatic pwm_pkg::pwm_cmd_u times_cmd(int ch, int t_on, int t_per);
    pwm_pkg::pwm_cmd_u c;
    c            = '0;
    c.cfg.op     = pwm_pkg::OP_SET_TIMES;
    c.cfg.chan   = ch[`PWM_CHAN_W-1:0];
    c.cfg.t_on   = t_on[`PWM_TIME_W-1:0];
    c.cfg.t_period = t_per[`PWM_TIME_W-1:0];
    return c;
  endfunction

  function automatic pwm_pkg::pwm_cmd_u enable_cmd(int mask);
    pwm_pkg::pwm_cmd_u c;
    c             = '0;
    c.ctl.op      = pwm_pkg::OP_ENABLE;
    c.ctl.en_mask = mask[`PWM_CHANNELS-1:0];
    return c;
  endfunction

  function automatic pwm_pkg::pwm_cmd_u read_cmd(int ch);
    pwm_pkg::pwm_cmd_u c;
    c          = '0;
    c.cfg.op   = pwm_pkg::OP_READ_STATUS;
    c.cfg.chan = ch[`PWM_CHAN_W-1:0];
    return c;
  endfunction

  function automatic pwm_pkg::pwm_cmd_u bad_cmd(int ch);
    pwm_pkg::pwm_cmd_u c;
    c        = times_cmd(ch, 1, 3);
    c.cfg.op = pwm_pkg::pwm_op_e'(2'b11); // unused opcode.
    return c;
  endfunction

  // ============================================================
  // command table
  // ============================================================
  function automatic void add_row(string name, pwm_pkg::pwm_cmd_u c, int ok, int en,
                                  int data, int wait_cyc);
    row_t r;
    r.name      = name;
    r.cmd       = c;
    r.exp_ok    = ok;
    r.exp_en    = en;
    r.exp_data  = data;
    r.cnt_tp    = 0;
    r.sync_chan = -1;
    r.wait_cyc  = wait_cyc;
    r.tim_chan  = -1;
    r.exp_width = 0;
    r.exp_space = 0;
    rows.push_back(r);
  endfunction

  function automatic void set_timing(int ch, int width, int space);
    row_t r;
    r           = rows.pop_back();
    r.tim_chan  = ch;
    r.exp_width = width;
    r.exp_space = space;
    rows.push_back(r);
  endfunction

  function automatic void set_count(int tp);
    row_t r;
    r        = rows.pop_back();
    r.cnt_tp = tp;
    rows.push_back(r);
  endfunction

  function automatic void set_sync(int ch);
    row_t r;
    r           = rows.pop_back();
    r.sync_chan = ch;
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
      add_row($sformatf("reset read ch%0d", ch), read_cmd(ch), 1, 0, 0, 0);
      set_timing(ch, 0, 0);  // no pulse yet.
    end
    add_row("set ch0", times_cmd(0, 3, 8), 1, -1, 0, 0);
    add_row("set ch1", times_cmd(1, 1, 2), 1, -1, 0, 0);
    add_row("set ch2", times_cmd(2, 5, 6), 1, -1, 0, 0);
    add_row("set ch3", times_cmd(3, 2, 10), 1, -1, 0, 0);
    add_row("ch1 zero on time", times_cmd(1, 0, 5), 0, -1, 0, 0);
    add_row("ch2 on equals period", times_cmd(2, 6, 6), 0, -1, 0, 0);
    add_row("ch3 on over period", times_cmd(3, 12, 10), 0, -1, 0, 0);
    add_row("illegal opcode", bad_cmd(0), 0, -1, 0, 0);
    add_row("enable all", enable_cmd(4'hf), 1, -1, 0, 60);
    add_row("count ch0", read_cmd(0), 1, 1, -1, 0);
    set_count(8);
    set_timing(0, 3, 10);
    add_row("count ch1", read_cmd(1), 1, 1, -1, 0);
    set_count(2);
    set_timing(1, 1, 4);
    add_row("count ch2", read_cmd(2), 1, 1, -1, 0);
    set_count(6);
    set_timing(2, 5, 8);
    add_row("count ch3", read_cmd(3), 1, 1, -1, 0);
    set_count(10);
    set_timing(3, 2, 12);
    // write lands in ch0's ON phase, that period keeps 3/8.
    add_row("ch0 new times", times_cmd(0, 2, 6), 1, -1, 0, 2);
    set_sync(0);
    set_timing(0, 3, 10);
    add_row("ch0 after update", read_cmd(0), 1, 1, -1, 40);
    set_timing(0, 2, 8);
    add_row("disable ch1 ch3", enable_cmd(4'b0101), 1, -1, 0, 30);
    add_row("ch3 stopped", read_cmd(3), 1, 0, -1, 40);
    add_row("ch3 count frozen", read_cmd(3), 1, 0, -2, 0);
    add_row("ch1 stopped", read_cmd(1), 1, 0, -1, 20);
    add_row("ch1 count frozen", read_cmd(1), 1, 0, -2, 0);
    add_row("ch2 still running", read_cmd(2), 1, 1, -1, 0);
    set_sync(2);  // a fresh pulse must still appear.
    set_timing(2, 5, 8);
  endfunction

  function automatic int table_cycles();
    int total;
    total = 3;
    foreach (rows[n]) begin
      total += rows[n].wait_cyc + 10;
      if (rows[n].sync_chan >= 0) total += 12;
    end
    return total;
  endfunction

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    row_t r;
    int   ok;
    int   en;
    int   data;
    int   at_cyc;
    int   e;
    reset = 1'b0;
    req   = 1'b0;
    cmd   = '0;
    build_table();
    limit       = table_cycles() * 4 + 100;
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;
    foreach (rows[n]) begin
      r = rows[n];
      if (r.sync_chan >= 0) wait_rise(r.sync_chan);
      exchange(r.cmd, ok, en, data, at_cyc);
      check({r.name, " ok"}, r.exp_ok, ok);
      if (r.exp_en >= 0) check({r.name, " enabled"}, r.exp_en, en);
      if (r.cnt_tp > 0) begin
        e = (at_cyc - en_cycle - 1) / (r.cnt_tp + 2);
        // one period of slack either way.
        if (data < e - 1 || data > e + 1) check({r.name, " data"}, e, data);
      end else if (r.exp_data == -2) begin
        check({r.name, " data"}, last_data, data);
      end else if (r.exp_data >= 0) begin
        check({r.name, " data"}, r.exp_data, data);
      end
      last_data = data;
      if (r.cmd.cfg.op == pwm_pkg::OP_ENABLE && ok == 1) en_cycle = at_cyc;
      repeat (r.wait_cyc) @(negedge clk);
      if (r.tim_chan >= 0) begin
        @(posedge clk);  // monitor settles on falling edges.
        check({r.name, " width"}, r.exp_width, last_width[r.tim_chan]);
        check({r.name, " spacing"}, r.exp_space, last_space[r.tim_chan]);
      end
    end
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog.
  initial begin
    wait (table_ready);
    repeat (limit) @(posedge clk);
    $display("timeout, the command table did not finish within %0d cycles", limit);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- pwm_unit.f
+incdir+verilog
verilog/pwm_pkg.sv
verilog/pwm_cmd_decoder.sv
verilog/pwm_channel.sv
verilog/pwm_status.sv
verilog/pwm_unit.sv
sim/pwm_unit_props.sv
sim/pwm_unit_tb.sv
